// File: Bender.yml
package:
  name: fm_operator_pipeline

sources:
  - hw/fm_pkg.sv
  - hw/stage_phase_accumulator.sv
  - hw/stage_phase_modulator.sv
  - hw/stage_waveform_generator.sv
  - hw/stage_output_level.sv
  - hw/fm_operator_pipeline.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/fm_operator_pipeline_chk.sv
      - sim/tb_fm_operator_pipeline.sv

// File: compile.f
hw/fm_pkg.sv
hw/stage_phase_accumulator.sv
hw/stage_phase_modulator.sv
hw/stage_waveform_generator.sv
hw/stage_output_level.sv
hw/fm_operator_pipeline.sv
sim/tb_clock_gen.sv
sim/fm_operator_pipeline_chk.sv
sim/tb_fm_operator_pipeline.sv

// File: hw/fm_operator_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

module fm_operator_pipeline (
    input  wire logic                           i_Clock,
    input  wire logic                           i_arst_n,

    // One slot per clock
    input  wire fm_pkg::op_ctx_t                i_ctx,
    input  wire logic [fm_pkg::FREQ_W-1:0]      i_freq,

    // Sine table load
    input  wire logic                           i_table_we,
    input  wire logic [fm_pkg::TABLE_AW-1:0]    i_table_addr,
    input  wire logic [fm_pkg::SAMPLE_W-1:0]    i_table_data,

    output fm_pkg::op_ctx_t                     o_ctx,
    output logic signed [fm_pkg::SAMPLE_W-1:0]  o_sample
);

    // Sum of the stage depths below
    localparam int STAGE_DEPTH = 1 + 1 + 3 + 1;

    if (STAGE_DEPTH != fm_pkg::PIPE_LATENCY) begin : g_depth_check
        $error("stage depths do not add up to PIPE_LATENCY");
    end

    // ------------------------------
    // Inter-stage signals
    // ------------------------------

    fm_pkg::op_ctx_t                    acc_ctx;
    logic [fm_pkg::PHASE_W-1:0]         acc_phase;
    fm_pkg::op_ctx_t                    mod_ctx;
    logic [fm_pkg::PHASE_W-1:0]         mod_phase;
    fm_pkg::op_ctx_t                    wav_ctx;
    logic signed [fm_pkg::SAMPLE_W-1:0] wav_waveform;

    // Feedback from output level to modulator
    logic                               fb_we;
    logic [fm_pkg::SLOT_W-1:0]          fb_slot;
    logic signed [fm_pkg::SAMPLE_W-1:0] fb_sample;

    // ------------------------------
    // Stage chain
    // ------------------------------

    stage_phase_accumulator u_accumulator (
        .i_Clock  (i_Clock),
        .i_arst_n (i_arst_n),
        .i_ctx    (i_ctx),
        .i_freq   (i_freq),
        .o_ctx    (acc_ctx),
        .o_phase  (acc_phase)
    );

    stage_phase_modulator u_modulator (
        .i_Clock     (i_Clock),
        .i_arst_n    (i_arst_n),
        .i_ctx       (acc_ctx),
        .i_phase     (acc_phase),
        .i_fb_we     (fb_we),
        .i_fb_slot   (fb_slot),
        .i_fb_sample (fb_sample),
        .o_ctx       (mod_ctx),
        .o_phase     (mod_phase)
    );

    stage_waveform_generator u_waveform (
        .i_Clock      (i_Clock),
        .i_arst_n     (i_arst_n),
        .i_ctx        (mod_ctx),
        .i_phase      (mod_phase),
        .i_table_we   (i_table_we),
        .i_table_addr (i_table_addr),
        .i_table_data (i_table_data),
        .o_ctx        (wav_ctx),
        .o_waveform   (wav_waveform)
    );

    stage_output_level u_output_level (
        .i_Clock     (i_Clock),
        .i_arst_n    (i_arst_n),
        .i_ctx       (wav_ctx),
        .i_waveform  (wav_waveform),
        .o_ctx       (o_ctx),
        .o_sample    (o_sample),
        .o_fb_we     (fb_we),
        .o_fb_slot   (fb_slot),
        .o_fb_sample (fb_sample)
    );

endmodule

`default_nettype wire

// File: hw/fm_pkg.sv
`default_nettype none

package fm_pkg;

    // ------------------------------
    // Sizes and counts
    // ------------------------------

    // Voice-operator slots per frame
    localparam int NUM_SLOTS = 16;
    localparam int SLOT_W = 4;

    // Phase word layout from the top bit down
    // Sign (ignored), half-wave negate, quadrant mirror, 14 index bits
    localparam int PHASE_W = 17;
    localparam int FREQ_W = 17;

    // Quarter-wave table depth
    localparam int TABLE_AW = 14;

    // Signed sample as it leaves the pipeline
    localparam int SAMPLE_W = 16;

    // Right-shift amount field
    localparam int ATTEN_W = 4;

    // Sample to phase offset scaling
    localparam int MOD_SHIFT = 1;

    // Accumulator 1, modulator 1, waveform 3, output level 1
    localparam int PIPE_LATENCY = 6;

    // ------------------------------
    // Types
    // ------------------------------

    // Where the modulation offset comes from
    typedef enum logic [1:0] {
        MOD_NONE   = 2'd0,
        MOD_SELF   = 2'd1,
        MOD_SOURCE = 2'd2
    } mod_mode_e;

    // Per-operator algorithm word, 10 bits
    typedef struct packed {
        mod_mode_e              mod_mode;
        logic [SLOT_W-1:0]      mod_source;
        logic [ATTEN_W-1:0]     attenuation;
    } algorithm_word_t;

    // Rides beside the data through every stage
    typedef struct packed {
        logic [SLOT_W-1:0]      slot;
        algorithm_word_t        algorithm;
        logic                   note_on;
    } op_ctx_t;

endpackage

`default_nettype wire

// File: hw/stage_output_level.sv
`timescale 1ns/1ns
`default_nettype none

module stage_output_level (
    input  wire logic                               i_Clock,
    input  wire logic                               i_arst_n,

    input  wire fm_pkg::op_ctx_t                    i_ctx,
    input  wire logic signed [fm_pkg::SAMPLE_W-1:0] i_waveform,

    output fm_pkg::op_ctx_t                         o_ctx,
    output logic signed [fm_pkg::SAMPLE_W-1:0]      o_sample,

    // Back to the modulator sample store
    output logic                                    o_fb_we,
    output logic [fm_pkg::SLOT_W-1:0]               o_fb_slot,
    output logic signed [fm_pkg::SAMPLE_W-1:0]      o_fb_sample
);

    // Low through reset, then one write per slot
    logic fb_we_q;

    // ------------------------------
    // Level and mute
    // ------------------------------

    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_sample <= '0;
            o_ctx    <= '0;
            fb_we_q  <= 1'b0;
        end else begin
            if (i_ctx.note_on) begin
                // Arithmetic shift keeps the sign
                o_sample <= i_waveform >>> i_ctx.algorithm.attenuation;
            end else begin
                // Muted slot also clears its stored sample
                o_sample <= '0;
            end
            o_ctx   <= i_ctx;
            fb_we_q <= 1'b1;
        end
    end

    // Same cycle as the output
    assign o_fb_we     = fb_we_q;
    assign o_fb_slot   = o_ctx.slot;
    assign o_fb_sample = o_sample;

endmodule

`default_nettype wire

// File: hw/stage_phase_accumulator.sv
`timescale 1ns/1ns
`default_nettype none

module stage_phase_accumulator (
    input  wire logic                       i_Clock,
    input  wire logic                       i_arst_n,

    input  wire fm_pkg::op_ctx_t            i_ctx,
    input  wire logic [fm_pkg::FREQ_W-1:0]  i_freq,

    output fm_pkg::op_ctx_t                 o_ctx,
    output logic [fm_pkg::PHASE_W-1:0]      o_phase
);

    // ------------------------------
    // Phase register file
    // ------------------------------

    // One running phase per slot
    logic [fm_pkg::PHASE_W-1:0] phase_mem [fm_pkg::NUM_SLOTS];

    // Phase for the slot now at the input
    logic [fm_pkg::PHASE_W-1:0] next_phase;

    always_comb begin
        if (i_ctx.note_on) begin
            // Wraps at PHASE_W bits
            next_phase = phase_mem[i_ctx.slot] + fm_pkg::PHASE_W'(i_freq);
        end else begin
            // Note off restarts the wave at phase zero
            next_phase = '0;
        end
    end

    // ------------------------------
    // State update
    // ------------------------------

    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < fm_pkg::NUM_SLOTS; i++) begin
                phase_mem[i] <= '0;
            end
            o_ctx <= '0;
        end else begin
            // Only the visiting slot advances
            phase_mem[i_ctx.slot] <= next_phase;
            o_ctx <= i_ctx;
        end
    end

    // Outgoing phase equals the stored value
    always_ff @(posedge i_Clock) begin
        o_phase <= next_phase;
    end

endmodule

`default_nettype wire

// File: hw/stage_phase_modulator.sv
`timescale 1ns/1ns
`default_nettype none

module stage_phase_modulator (
    input  wire logic                               i_Clock,
    input  wire logic                               i_arst_n,

    input  wire fm_pkg::op_ctx_t                    i_ctx,
    input  wire logic [fm_pkg::PHASE_W-1:0]         i_phase,

    // Finished samples coming back from the output level
    input  wire logic                               i_fb_we,
    input  wire logic [fm_pkg::SLOT_W-1:0]          i_fb_slot,
    input  wire logic signed [fm_pkg::SAMPLE_W-1:0] i_fb_sample,

    output fm_pkg::op_ctx_t                         o_ctx,
    output logic [fm_pkg::PHASE_W-1:0]              o_phase
);

    // Last finished sample of each slot
    logic [fm_pkg::SAMPLE_W-1:0] sample_mem [fm_pkg::NUM_SLOTS];

    // Picked modulator sample and its phase offset
    logic [fm_pkg::SAMPLE_W-1:0] sel_sample;
    logic [fm_pkg::PHASE_W-1:0]  sel_ext;
    logic [fm_pkg::PHASE_W-1:0]  mod_offset;

    // ------------------------------
    // Offset selection
    // ------------------------------

    always_comb begin
        case (i_ctx.algorithm.mod_mode)
            fm_pkg::MOD_SELF:   sel_sample = sample_mem[i_ctx.slot];
            fm_pkg::MOD_SOURCE: sel_sample = sample_mem[i_ctx.algorithm.mod_source];
            default:            sel_sample = '0;
        endcase

        // Sign extend to phase width
        sel_ext = {{(fm_pkg::PHASE_W - fm_pkg::SAMPLE_W){sel_sample[fm_pkg::SAMPLE_W-1]}},
                   sel_sample};
        mod_offset = sel_ext << fm_pkg::MOD_SHIFT;
    end

    // ------------------------------
    // Sample store and context
    // ------------------------------

    // Read above sees the old word on a same-cycle write
    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < fm_pkg::NUM_SLOTS; i++) begin
                sample_mem[i] <= '0;
            end
            o_ctx <= '0;
        end else begin
            if (i_fb_we) begin
                sample_mem[i_fb_slot] <= i_fb_sample;
            end
            o_ctx <= i_ctx;
        end
    end

    // Wraps at PHASE_W bits
    always_ff @(posedge i_Clock) begin
        o_phase <= i_phase + mod_offset;
    end

endmodule

`default_nettype wire

// File: hw/stage_waveform_generator.sv
`timescale 1ns/1ns
`default_nettype none

module stage_waveform_generator (
    input  wire logic                               i_Clock,
    input  wire logic                               i_arst_n,

    input  wire fm_pkg::op_ctx_t                    i_ctx,
    // Top bit is a sign and plays no part in the lookup
    input  wire logic [fm_pkg::PHASE_W-1:0]         i_phase,

    // Quarter-wave table write port
    input  wire logic                               i_table_we,
    input  wire logic [fm_pkg::TABLE_AW-1:0]        i_table_addr,
    input  wire logic [fm_pkg::SAMPLE_W-1:0]        i_table_data,

    output fm_pkg::op_ctx_t                         o_ctx,
    output logic signed [fm_pkg::SAMPLE_W-1:0]      o_waveform
);

    // ------------------------------
    // Quarter-wave sine table
    // ------------------------------

    // Bit 15 of each word is rebuilt from the phase
    logic [fm_pkg::SAMPLE_W-1:0] sine_table [2**fm_pkg::TABLE_AW];
    logic [fm_pkg::SAMPLE_W-1:0] table_word;

    // Folded table index from clock 1
    logic [fm_pkg::TABLE_AW-1:0] phase_arg;

    assign table_word = sine_table[phase_arg];

    always_ff @(posedge i_Clock) begin
        if (i_table_we) begin
            sine_table[i_table_addr] <= i_table_data;
        end
    end

    // ------------------------------
    // Phase decode
    // ------------------------------

    // Second half of the wave
    logic                        negate_out;
    // Second and fourth quadrant
    logic                        mirror_idx;
    logic [fm_pkg::TABLE_AW-1:0] raw_idx;

    always_comb begin
        negate_out = i_phase[fm_pkg::PHASE_W-2];
        mirror_idx = i_phase[fm_pkg::PHASE_W-3];
        raw_idx    = i_phase[fm_pkg::TABLE_AW-1:0];
    end

    // Delayed negate flag and registered table magnitude
    logic [1:0]                  negate_q;
    logic [fm_pkg::SAMPLE_W-2:0] quarter_mag;
    logic [fm_pkg::SAMPLE_W-1:0] quarter_wave;

    assign quarter_wave = {1'b0, quarter_mag};

    always_ff @(posedge i_Clock) begin
        // Clock 1
        negate_q[0] <= negate_out;
        phase_arg   <= mirror_idx ? ~raw_idx : raw_idx;

        // Clock 2
        negate_q[1] <= negate_q[0];
        quarter_mag <= table_word[fm_pkg::SAMPLE_W-2:0];

        // Clock 3, bitwise inversion for the lower half
        o_waveform  <= negate_q[1] ? ~quarter_wave : quarter_wave;
    end

    // ------------------------------
    // Context delay line
    // ------------------------------

    // Three deep, in step with the data above
    fm_pkg::op_ctx_t ctx_q [2];

    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ctx_q[0] <= '0;
            ctx_q[1] <= '0;
            o_ctx    <= '0;
        end else begin
            ctx_q[0] <= i_ctx;
            ctx_q[1] <= ctx_q[0];
            o_ctx    <= ctx_q[1];
        end
    end

endmodule

`default_nettype wire

// File: sim/fm_operator_pipeline_chk.sv
`timescale 1ns/1ns
`default_nettype none

module fm_operator_pipeline_chk (
    input wire logic                               i_Clock,
    input wire logic                               i_arst_n,
    input wire fm_pkg::op_ctx_t                    i_ctx_out,
    input wire logic signed [fm_pkg::SAMPLE_W-1:0] i_sample_out,
    // Reference model values, already delayed to line up with the outputs
    input wire fm_pkg::op_ctx_t                    i_exp_ctx,
    input wire logic signed [fm_pkg::SAMPLE_W-1:0] i_exp_sample
);

    // Failed checks so far
    int unsigned err_count = 0;

    // Context comes out unchanged
    a_ctx_match: assert property (@(posedge i_Clock) disable iff (!i_arst_n)
        i_ctx_out == i_exp_ctx)
    else begin
        err_count++;
        $error("ERR %0t o_ctx expected %h got %h",
               $time, $sampled(i_exp_ctx), $sampled(i_ctx_out));
    end

    // Sample value against the model
    a_sample_match: assert property (@(posedge i_Clock) disable iff (!i_arst_n)
        i_sample_out == i_exp_sample)
    else begin
        err_count++;
        $error("ERR %0t o_sample expected %0d got %0d",
               $time, $sampled(i_exp_sample), $sampled(i_sample_out));
    end

    // Note off always silent
    a_mute: assert property (@(posedge i_Clock) disable iff (!i_arst_n)
        !i_ctx_out.note_on |-> i_sample_out == '0)
    else begin
        err_count++;
        $error("ERR %0t o_sample expected 0 got %0d", $time, $sampled(i_sample_out));
    end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic o_clock,
    output logic o_arst_n
);

    // 8 ns period
    initial begin
        o_clock = 1'b0;
        forever #4 o_clock = ~o_clock;
    end

    // Low for 5 cycles, released away from the rising edge
    initial begin
        o_arst_n = 1'b0;
        repeat (5) @(posedge o_clock);
        @(negedge o_clock);
        o_arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/tb_fm_operator_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fm_operator_pipeline;

    // ------------------------------
    // Run length
    // ------------------------------
    localparam int LAT = fm_pkg::PIPE_LATENCY;
    localparam int DRAIN = LAT + 2;
    localparam int FILL_LEN = 2**fm_pkg::TABLE_AW;
    localparam int TEST_CYCLES = FILL_LEN + 64 + 8 + 32 + 96 + 15 + 6 * DRAIN;
    // Reset plus all tests plus slack at 8 ns per clock
    localparam int WATCHDOG_NS = (5 + TEST_CYCLES + 200) * 8;

    logic                               i_Clock;
    logic                               i_arst_n;
    fm_pkg::op_ctx_t                    i_ctx;
    logic [fm_pkg::FREQ_W-1:0]          i_freq;
    logic                               i_table_we;
    logic [fm_pkg::TABLE_AW-1:0]        i_table_addr;
    logic [fm_pkg::SAMPLE_W-1:0]        i_table_data;
    fm_pkg::op_ctx_t                    o_ctx;
    logic signed [fm_pkg::SAMPLE_W-1:0] o_sample;

    // ------------------------------
    // Reference model state
    // ------------------------------
    logic [fm_pkg::PHASE_W-1:0]         ph_model [fm_pkg::NUM_SLOTS];
    logic signed [fm_pkg::SAMPLE_W-1:0] smp_model [fm_pkg::NUM_SLOTS];
    logic [fm_pkg::SAMPLE_W-1:0]        tbl_model [2**fm_pkg::TABLE_AW];
    // Feedback writes still on their way back
    logic [fm_pkg::SLOT_W-1:0]          wr_slot [LAT];
    logic signed [fm_pkg::SAMPLE_W-1:0] wr_smp [LAT];
    // One extra entry since the model runs on the drive edge
    fm_pkg::op_ctx_t                    exp_ctx_q [LAT+1];
    logic signed [fm_pkg::SAMPLE_W-1:0] exp_smp_q [LAT+1];
    fm_pkg::op_ctx_t                    exp_ctx;
    logic signed [fm_pkg::SAMPLE_W-1:0] exp_sample;
    integer                             seed;
    int unsigned                        tests_passed;
    int unsigned                        tests_failed;

    assign exp_ctx    = exp_ctx_q[LAT];
    assign exp_sample = exp_smp_q[LAT];

    tb_clock_gen u_clock_gen (
        .o_clock  (i_Clock),
        .o_arst_n (i_arst_n)
    );

    fm_operator_pipeline i_dut (
        .i_Clock      (i_Clock),
        .i_arst_n     (i_arst_n),
        .i_ctx        (i_ctx),
        .i_freq       (i_freq),
        .i_table_we   (i_table_we),
        .i_table_addr (i_table_addr),
        .i_table_data (i_table_data),
        .o_ctx        (o_ctx),
        .o_sample     (o_sample)
    );

    bind fm_operator_pipeline fm_operator_pipeline_chk u_chk (
        .i_Clock      (i_Clock),
        .i_arst_n     (i_arst_n),
        .i_ctx_out    (o_ctx),
        .i_sample_out (o_sample),
        .i_exp_ctx    (tb_fm_operator_pipeline.exp_ctx),
        .i_exp_sample (tb_fm_operator_pipeline.exp_sample)
    );

    function automatic fm_pkg::op_ctx_t build_ctx(input logic [3:0] slot,
        input fm_pkg::mod_mode_e mode, input logic [3:0] src, input logic [3:0] atten,
        input logic note_on);
        fm_pkg::op_ctx_t c;
        c.slot = slot;
        c.algorithm.mod_mode = mode;
        c.algorithm.mod_source = src;
        c.algorithm.attenuation = atten;
        c.note_on = note_on;
        return c;
    endfunction

    // Quarter-wave rebuild from the quadrant bits
    function automatic logic signed [15:0] fold_wave(input logic [16:0] ph);
        logic [13:0] idx;
        logic [15:0] mag;
        idx = ph[14] ? ~ph[13:0] : ph[13:0];
        mag = {1'b0, tbl_model[idx][14:0]};
        return ph[15] ? ~mag : mag;
    endfunction

    task automatic model_step(input fm_pkg::op_ctx_t ctx, input logic [16:0] freq);
        logic signed [15:0] src_smp;
        logic [16:0]        mphase;
        logic signed [15:0] wave;
        logic signed [15:0] result;
        // Sample of the input six steps back is visible to this one
        smp_model[wr_slot[LAT-1]] = wr_smp[LAT-1];
        for (int i = LAT - 1; i > 0; i--) begin
            wr_slot[i] = wr_slot[i-1];
            wr_smp[i]  = wr_smp[i-1];
        end
        ph_model[ctx.slot] = ctx.note_on ? ph_model[ctx.slot] + freq : 17'd0;
        case (ctx.algorithm.mod_mode)
            fm_pkg::MOD_SELF:   src_smp = smp_model[ctx.slot];
            fm_pkg::MOD_SOURCE: src_smp = smp_model[ctx.algorithm.mod_source];
            default:            src_smp = '0;
        endcase
        mphase = ph_model[ctx.slot] + ({src_smp[15], src_smp} << fm_pkg::MOD_SHIFT);
        wave = fold_wave(mphase);
        if (ctx.note_on) begin
            result = wave >>> ctx.algorithm.attenuation;
        end else begin
            result = '0;
        end
        wr_slot[0] = ctx.slot;
        wr_smp[0]  = result;
        for (int i = LAT; i > 0; i--) begin
            exp_ctx_q[i] <= exp_ctx_q[i-1];
            exp_smp_q[i] <= exp_smp_q[i-1];
        end
        exp_ctx_q[0] <= ctx;
        exp_smp_q[0] <= result;
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic drive_cycle(input fm_pkg::op_ctx_t ctx, input logic [16:0] freq,
        input logic we, input logic [13:0] addr, input logic [15:0] data);
        @(posedge i_Clock);
        i_ctx        <= ctx;
        i_freq       <= freq;
        i_table_we   <= we;
        i_table_addr <= addr;
        i_table_data <= data;
        if (we) begin
            tbl_model[addr] = data;
        end
        model_step(ctx, freq);
    endtask

    task automatic drive_slot(input fm_pkg::op_ctx_t ctx, input logic [16:0] freq);
        drive_cycle(ctx, freq, 1'b0, '0, '0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_slot(build_ctx(4'd0, fm_pkg::MOD_NONE, 4'd0, 4'd0, 1'b0), '0);
    endtask

    // Phase zero on note off and then one step onto the address
    task automatic read_table_word(input logic [13:0] addr);
        drive_slot(build_ctx(4'd4, fm_pkg::MOD_NONE, 4'd0, 4'd0, 1'b0), '0);
        drive_slot(build_ctx(4'd4, fm_pkg::MOD_NONE, 4'd0, 4'd0, 1'b1), 17'(addr));
    endtask

    task automatic finish_test(input string name, input int unsigned errs_before);
        int unsigned errs;
        idle_cycles(DRAIN);
        errs = i_dut.u_chk.err_count - errs_before;
        if (errs == 0) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d assertion errors", name, errs);
        end
    endtask

    initial begin
        int unsigned        errs;
        fm_pkg::mod_mode_e  mode;
        logic [3:0]         src;
        logic [3:0]         atten;
        logic [16:0]        freq;
        logic               key_on;
        i_ctx        = '0;
        i_freq       = '0;
        i_table_we   = 1'b0;
        i_table_addr = '0;
        i_table_data = '0;
        seed         = 32'hf9be;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < fm_pkg::NUM_SLOTS; i++) begin
            ph_model[i]  = '0;
            smp_model[i] = '0;
        end
        for (int i = 0; i < LAT; i++) begin
            wr_slot[i] = '0;
            wr_smp[i]  = '0;
        end
        for (int i = 0; i <= LAT; i++) begin
            exp_ctx_q[i] = '0;
            exp_smp_q[i] = '0;
        end
        @(posedge i_arst_n);

        // Outputs stay silent while the ramp goes in
        errs = i_dut.u_chk.err_count;
        for (int a = 0; a < FILL_LEN; a++) begin
            drive_cycle(build_ctx(4'd0, fm_pkg::MOD_NONE, 4'd0, 4'd0, 1'b0), '0,
                        1'b1, 14'(a), 16'(a * 2));
        end
        finish_test("reset and table fill", errs);

        // Four frames of all 16 slots back to back
        errs = i_dut.u_chk.err_count;
        for (int i = 0; i < 64; i++) begin
            drive_slot(build_ctx(4'(i), fm_pkg::MOD_NONE, 4'(i / 3), 4'(i % 4), (i % 5) != 2),
                       17'(i * 1031 + 77));
        end
        finish_test("context pass-through", errs);

        // Steps of a quarter turn plus 5 walk through every quadrant
        errs = i_dut.u_chk.err_count;
        drive_slot(build_ctx(4'd1, fm_pkg::MOD_NONE, 4'd0, 4'd0, 1'b0), '0);
        repeat (7) drive_slot(build_ctx(4'd1, fm_pkg::MOD_NONE, 4'd0, 4'd0, 1'b1), 17'h04005);
        finish_test("quadrant folding", errs);

        // Muted steps take an offset from slot 2 so their wave is not zero
        errs = i_dut.u_chk.err_count;
        for (int i = 0; i < 32; i++) begin
            key_on = (i % 6) != 5;
            mode   = key_on ? fm_pkg::MOD_NONE : fm_pkg::MOD_SOURCE;
            drive_slot(build_ctx(4'(2 + i % 2), mode, 4'd2, 4'(i / 2), key_on), 17'h00c35);
        end
        finish_test("attenuation and note-off", errs);

        errs = i_dut.u_chk.err_count;
        for (int i = 0; i < 96; i++) begin
            mode  = ($random(seed) & 1) ? fm_pkg::MOD_SELF : fm_pkg::MOD_SOURCE;
            src   = 4'($random(seed));
            atten = 4'($random(seed) & 3);
            freq  = 17'($random(seed));
            drive_slot(build_ctx(4'(i % 8), mode, src, atten, 1'b1), freq);
        end
        finish_test("modulation", errs);

        // Quiet gap so no read in flight meets the new words
        errs = i_dut.u_chk.err_count;
        idle_cycles(3);
        drive_cycle(build_ctx(4'd0, fm_pkg::MOD_NONE, 4'd0, 4'd0, 1'b0), '0,
                    1'b1, 14'd100, 16'h1234);
        drive_cycle(build_ctx(4'd0, fm_pkg::MOD_NONE, 4'd0, 4'd0, 1'b0), '0,
                    1'b1, 14'd2000, 16'h0f0f);
        drive_cycle(build_ctx(4'd0, fm_pkg::MOD_NONE, 4'd0, 4'd0, 1'b0), '0,
                    1'b1, 14'd9000, 16'h7001);
        drive_cycle(build_ctx(4'd0, fm_pkg::MOD_NONE, 4'd0, 4'd0, 1'b0), '0,
                    1'b1, 14'd16000, 16'h2222);
        read_table_word(14'd100);
        read_table_word(14'd2000);
        read_table_word(14'd9000);
        read_table_word(14'd16000);
        finish_test("table rewrite", errs);

        $display("tests run %0d, passed %0d, failed %0d, assertion errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed,
                 i_dut.u_chk.err_count);
        if (tests_failed == 0 && i_dut.u_chk.err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // ------------------------------
    // Watchdog
    // ------------------------------
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout after %0d ns, stimulus did not finish", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
